// File: irq_pkg.sv
// shared types for the interrupt unit; the encoder and vector math assume exactly eight lines
package irq_pkg;

    // ==============================
    // sizes
    // ==============================

    // one bit per line, the encoder splits this into two nibbles
    localparam int NUM_IRQ = 8;

    localparam int ID_W   = 3;  // log2 of the line count
    localparam int ADDR_W = 32; // handler address width

    // ==============================
    // vector types
    // ==============================

    // lines, pending set, in-service set and claim mask
    typedef logic [NUM_IRQ-1:0] irq_vec_t;

    // source number, 7 has the highest priority
    typedef logic [ID_W-1:0] irq_id_t;

    // handler entry point
    typedef logic [ADDR_W-1:0] isr_addr_t;

    // ==============================
    // handshake FSM
    // ==============================

    // IDLE    no request out
    // REQ     irq_req raised, waiting for ack
    // RELEASE irq_req dropped, waiting for ack to fall
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        REQ     = 2'd1,
        RELEASE = 2'd2
    } hs_state_t;

endpackage

// File: irq_pending.sv
// lines are level sensitive and must stay high until their request is acknowledged
`timescale 1ns/10ps

module irq_pending (
    input  logic              clk,
    input  logic              rst_n,
    input  irq_pkg::irq_vec_t irq_lines,
    input  logic              claim,
    input  irq_pkg::irq_id_t  claim_id,
    output irq_pkg::irq_vec_t pending
);
    import irq_pkg::*;

    irq_vec_t in_service;   // sources currently being handled
    irq_vec_t claim_mask;   // one-hot of claim_id when claiming
    irq_vec_t in_service_d;
    irq_vec_t seen;         // in service or waiting

    // ==============================
    // claim decode
    // ==============================
    always_comb begin
        for (int i = 0; i < NUM_IRQ; i++) begin
            claim_mask[i] = claim && (claim_id == irq_id_t'(i));
        end
    end

    // a low line drops its bit, so a claim on a released line leaves it clear
    assign in_service_d = (in_service | claim_mask) & irq_lines;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_service <= '0;
        end else begin
            in_service <= in_service_d;
        end
    end

    // hide everything already in service
    assign pending = irq_lines & ~in_service;

    assign seen = in_service | pending;

    // ==============================
    // checks
    // ==============================

    // the FSM must only claim what this block offered or already holds
    a_claim_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        claim |-> |($past(seen) & claim_mask)
    ) else $error("claim of id %0d that was neither pending nor in service", claim_id);

endmodule

// File: irq_prio_enc.sv
// built for exactly eight lines; id is zero when nothing is pending
`timescale 1ns/10ps

module irq_prio_enc (
    input  irq_pkg::irq_vec_t pending,
    output irq_pkg::irq_id_t  sel_id,
    output logic              any_pending
);
    import irq_pkg::*;

    localparam int HALF = NUM_IRQ / 2; // one nibble

    logic [HALF-1:0] upper_nib;
    logic [HALF-1:0] lower_nib;
    logic            upper_nz;
    logic            lower_nz;
    logic [1:0]      upper_prio;
    logic [1:0]      lower_prio;

    // ==============================
    // nibble encoder
    // ==============================

    // index of the highest set bit, zero for an empty nibble
    function automatic logic [1:0] nibble_prio(input logic [3:0] nib);
        logic [1:0] prio;
        casez (nib)
            4'b1???: prio = 2'd3;
            4'b01??: prio = 2'd2;
            4'b001?: prio = 2'd1;
            default: prio = 2'd0;
        endcase
        return prio;
    endfunction

    assign upper_nib = pending[NUM_IRQ-1:HALF];
    assign lower_nib = pending[HALF-1:0];

    // both halves resolve in parallel
    assign upper_prio = nibble_prio(upper_nib);
    assign lower_prio = nibble_prio(lower_nib);

    assign upper_nz = |upper_nib;
    assign lower_nz = |lower_nib;

    // ==============================
    // merge
    // ==============================

    // upper half always wins, an empty lower half encodes to id 0
    assign sel_id = upper_nz ? {1'b1, upper_prio} : {1'b0, lower_prio};

    assign any_pending = upper_nz | lower_nz;

endmodule

// File: irq_vector.sv
// vectored slots are eight bytes apart; mode and id are sampled only on capture
`timescale 1ns/10ps

module irq_vector #(
    parameter irq_pkg::isr_addr_t DIRECT_BASE = 32'hB000_0000,
    parameter irq_pkg::isr_addr_t VECTOR_BASE = 32'hB100_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               capture,
    input  irq_pkg::irq_id_t   sel_id,
    input  logic               mode_sel,  // 0 direct, 1 vectored
    output irq_pkg::isr_addr_t isr_addr,
    output irq_pkg::irq_id_t   irq_id
);
    import irq_pkg::*;

    isr_addr_t vec_offset;
    isr_addr_t addr_d;

    // ==============================
    // address select
    // ==============================
    assign vec_offset = {26'd0, sel_id, 3'b000};          // id times eight
    assign addr_d     = mode_sel ? (VECTOR_BASE + vec_offset)
                                 : DIRECT_BASE;           // single shared handler

    // ==============================
    // hold until the next capture
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            isr_addr <= '0;
            irq_id   <= '0;
        end else if (capture) begin
            isr_addr <= addr_d;
            irq_id   <= sel_id;
        end
    end

endmodule

// File: irq_ack_timer.sv
// ACK_TIMEOUT must be at least 1; the count restarts from zero whenever timer_run drops
`timescale 1ns/10ps

module irq_ack_timer #(
    parameter int ACK_TIMEOUT = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_run,
    output logic expired
);

    localparam int CNT_W = (ACK_TIMEOUT > 1) ? $clog2(ACK_TIMEOUT) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(ACK_TIMEOUT - 1);

    logic [CNT_W-1:0] count;

    // ==============================
    // request age counter
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!timer_run || expired) begin
            count <= '0;  // wrap at expiry, FSM leaves REQ on this edge
        end else begin
            count <= count + 1'b1;
        end
    end

    assign expired = timer_run && (count == LAST);

    // ==============================
    // checks
    // ==============================
    a_count_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= LAST
    ) else $error("ack timer count %0d beyond limit %0d", count, LAST);

endmodule

// File: irq_handshake_fsm.sv
// one request in flight; the CPU must keep irq_ack low until irq_req rises again
`timescale 1ns/10ps

module irq_handshake_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic any_pending,
    input  logic irq_ack,
    input  logic expired,
    output logic capture,
    output logic claim,
    output logic timer_run,
    output logic irq_req,
    output logic ack_timeout
);
    import irq_pkg::*;

    hs_state_t state;
    hs_state_t state_d;
    logic      timeout;  // withdraw without claim

    // ==============================
    // next state
    // ==============================
    always_comb begin
        state_d = state;
        capture = 1'b0;
        claim   = 1'b0;
        timeout = 1'b0;
        case (state)
            IDLE: begin
                if (any_pending) begin
                    capture = 1'b1;  // latch addr and id
                    state_d = REQ;
                end
            end
            REQ: begin
                if (irq_ack) begin
                    claim   = 1'b1;  // ack beats a same-cycle expiry
                    state_d = RELEASE;
                end else if (expired) begin
                    timeout = 1'b1;
                    state_d = IDLE;
                end
            end
            RELEASE: begin
                if (!irq_ack) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    assign timer_run = (state == REQ);

    // ==============================
    // state and outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            irq_req     <= 1'b0;
            ack_timeout <= 1'b0;
        end else begin
            state       <= state_d;
            irq_req     <= (state_d == REQ);
            ack_timeout <= timeout;  // single-cycle pulse
        end
    end

    // ==============================
    // checks
    // ==============================
    a_no_req_in_release : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == RELEASE) |-> !irq_req
    ) else $error("irq_req high while waiting for ack to fall");

    // relies on the CPU side of the four-phase protocol
    a_no_capture_on_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        capture |-> !irq_ack
    ) else $error("new request captured while irq_ack still high");

endmodule

// File: irq_vmu_top.sv
// eight level-sensitive lines, no masking and no nesting of running handlers
`timescale 1ns/10ps

module irq_vmu_top #(
    parameter irq_pkg::isr_addr_t DIRECT_BASE = 32'hB000_0000,
    parameter irq_pkg::isr_addr_t VECTOR_BASE = 32'hB100_0000,
    parameter int                 ACK_TIMEOUT = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  irq_pkg::irq_vec_t  irq_lines,
    input  logic               mode_sel,     // 0 direct, 1 vectored
    input  logic               irq_ack,
    output logic               irq_req,
    output irq_pkg::isr_addr_t isr_addr,
    output irq_pkg::irq_id_t   irq_id,
    output logic               ack_timeout
);
    import irq_pkg::*;

    irq_vec_t pending;
    irq_id_t  sel_id;
    logic     any_pending;
    logic     capture;
    logic     claim;
    logic     timer_run;
    logic     expired;

    // ==============================
    // datapath
    // ==============================
    irq_pending u_pending (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_lines (irq_lines),
        .claim     (claim),
        .claim_id  (irq_id),       // latched id is the one being acked
        .pending   (pending)
    );

    irq_prio_enc u_prio (
        .pending     (pending),
        .sel_id      (sel_id),
        .any_pending (any_pending)
    );

    irq_vector #(
        .DIRECT_BASE (DIRECT_BASE),
        .VECTOR_BASE (VECTOR_BASE)
    ) u_vector (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .sel_id   (sel_id),
        .mode_sel (mode_sel),
        .isr_addr (isr_addr),
        .irq_id   (irq_id)
    );

    // ==============================
    // control
    // ==============================
    irq_ack_timer #(
        .ACK_TIMEOUT (ACK_TIMEOUT)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .timer_run (timer_run),
        .expired   (expired)
    );

    irq_handshake_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .any_pending (any_pending),
        .irq_ack     (irq_ack),
        .expired     (expired),
        .capture     (capture),
        .claim       (claim),
        .timer_run   (timer_run),
        .irq_req     (irq_req),
        .ack_timeout (ack_timeout)
    );

endmodule

// File: tb_irq_vmu.sv
// testbench for irq_vmu_top; assumes delays below 32 cycles and the CPU acks only a raised irq_req
`timescale 1ns/10ps

module tb_irq_vmu;
    import irq_pkg::*;

    localparam isr_addr_t  DIRECT_BASE = 32'h0000_1000;
    localparam isr_addr_t  VECTOR_BASE = 32'h0000_2000;
    localparam int         ACK_TIMEOUT = 16;
    localparam int         N_DIRECTED  = 6;
    localparam int         NUM_ROWS    = 26;
    localparam int         MAX_DELAY   = 31;   // 5-bit random delays
    localparam int         CYCLE_LIMIT = NUM_ROWS * (ACK_TIMEOUT + MAX_DELAY + 10);
    localparam logic [7:0] NO_ACK      = 8'hff;

    typedef struct packed {
        irq_vec_t   lines;   // held during the handshake
        logic       mode;    // 0 direct, 1 vectored
        logic [7:0] delay;   // ack delay in cycles
        irq_vec_t   after;   // lines once the handshake is done
        logic       exp_to;  // timeout expected
    } row_t;

    logic      clk;
    logic      rst_n;
    irq_vec_t  irq_lines;
    logic      mode_sel;
    logic      irq_ack;
    logic      irq_req;
    isr_addr_t isr_addr;
    irq_id_t   irq_id;
    logic      ack_timeout;
    row_t      rows [NUM_ROWS];
    irq_vec_t  ins_model;      // reference in-service set
    int        cycles = 0;

    irq_vmu_top #(
        .DIRECT_BASE (DIRECT_BASE),
        .VECTOR_BASE (VECTOR_BASE),
        .ACK_TIMEOUT (ACK_TIMEOUT)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines   (irq_lines),
        .mode_sel    (mode_sel),
        .irq_ack     (irq_ack),
        .irq_req     (irq_req),
        .isr_addr    (isr_addr),
        .irq_id      (irq_id),
        .ack_timeout (ack_timeout)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run hung: no end after %0d cycles", cycles);
            $display("TESTS FAILED");
            $fatal(1, "watchdog limit reached");
        end
    end

    // ==============================
    // helpers and checks
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic irq_id_t highest_line(input irq_vec_t v);
        irq_id_t id;
        id = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (v[i]) begin
                id = irq_id_t'(i);  // last hit wins
            end
        end
        return id;
    endfunction

    task automatic check_addr(input isr_addr_t got, input isr_addr_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "address check");
        end
    endtask

    task automatic check_id(input irq_id_t got, input irq_id_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "id check");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "flag check");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // sample registered outputs, then drive
    endtask

    // ==============================
    // one table row with CPU ack model
    // ==============================
    task automatic run_row(input row_t r);
        irq_vec_t  pend;
        irq_id_t   exp_id;
        isr_addr_t exp_addr;
        int        n;
        logic      timed;
        irq_lines = r.lines;
        mode_sel  = r.mode;
        pend      = r.lines & ~ins_model;
        ins_model = ins_model & r.lines;
        if (pend == '0) begin
            repeat (3) begin
                next_cycle();
                check_flag(irq_req, 1'b0, "request with nothing pending");
            end
            irq_lines = r.lines & r.after;  // keeps the pending set empty
            ins_model = ins_model & irq_lines;
            next_cycle();
        end else begin
            exp_id   = highest_line(pend);
            exp_addr = r.mode ? VECTOR_BASE + isr_addr_t'(exp_id) * 8 : DIRECT_BASE;
            next_cycle();  // capture edge
            check_flag(irq_req, 1'b1, "irq_req one cycle after capture");
            check_id(irq_id, exp_id, "captured id");
            check_addr(isr_addr, exp_addr, "captured address");
            n = 0;
            while (irq_req && n < int'(r.delay)) begin
                next_cycle();
                n++;
            end
            timed = !irq_req;
            check_flag(timed, r.exp_to, "timeout outcome");
            check_flag(ack_timeout, r.exp_to, "ack_timeout level");
            if (timed) begin
                check_flag(n == ACK_TIMEOUT, 1'b1, "timeout after ACK_TIMEOUT edges");
                next_cycle();
                check_flag(ack_timeout, 1'b0, "ack_timeout one cycle wide");
                check_flag(irq_req, 1'b1, "request offered again");
                check_id(irq_id, exp_id, "re-offered id");
                check_addr(isr_addr, exp_addr, "re-offered address");
            end
            irq_ack = 1'b1;
            next_cycle();
            check_flag(irq_req, 1'b0, "irq_req drop after ack");
            ins_model = ins_model | ((irq_vec_t'(1) << exp_id) & r.lines);
            repeat (2) begin  // ack held, no new request may rise
                next_cycle();
                check_flag(irq_req, 1'b0, "irq_req while irq_ack high");
            end
            irq_ack   = 1'b0;
            irq_lines = r.after;
            ins_model = ins_model & r.after;
            next_cycle();  // back to IDLE
        end
    endtask

    initial begin
        logic [31:0] seed;
        clk       = 1'b0;
        rst_n     = 1'b0;
        irq_lines = '0;
        mode_sel  = 1'b0;
        irq_ack   = 1'b0;
        ins_model = '0;
        seed      = 32'hdbb55d43;
        rows[0] = '{8'h85, 1'b0, 8'd2,  8'h85, 1'b0};  // 7 wins, stays high
        rows[1] = '{8'h85, 1'b1, 8'd0,  8'h05, 1'b0};  // 7 in service, 2 offered
        rows[2] = '{8'h85, 1'b1, 8'd5,  8'h00, 1'b0};  // 7 released and back
        rows[3] = '{8'h30, 1'b0, NO_ACK, 8'h00, 1'b1};
        rows[4] = '{8'h30, 1'b1, 8'd15, 8'h10, 1'b0};  // ack on the expiry edge
        rows[5] = '{8'h10, 1'b1, 8'd1,  8'h00, 1'b0};
        for (int i = N_DIRECTED; i < NUM_ROWS; i++) begin
            seed           = xorshift(seed);
            rows[i].lines  = seed[7:0];
            rows[i].mode   = seed[8];
            rows[i].delay  = {3'b000, seed[20:16]};
            rows[i].after  = seed[31:24];
            rows[i].exp_to = (seed[20:16] >= ACK_TIMEOUT);
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_flag(irq_req, 1'b0, "irq_req after reset");
        check_flag(ack_timeout, 1'b0, "ack_timeout after reset");
        check_addr(isr_addr, '0, "isr_addr after reset");
        check_id(irq_id, '0, "irq_id after reset");
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
irq_pkg.sv
irq_pending.sv
irq_prio_enc.sv
irq_vector.sv
irq_ack_timer.sv
irq_handshake_fsm.sv
irq_vmu_top.sv
tb_irq_vmu.sv

// File: Makefile
SRCS = irq_pkg.sv irq_pending.sv irq_prio_enc.sv irq_vector.sv irq_ack_timer.sv \
       irq_handshake_fsm.sv irq_vmu_top.sv tb_irq_vmu.sv

.PHONY: run clean

run: obj_dir/Vtb_irq_vmu
	./obj_dir/Vtb_irq_vmu

obj_dir/Vtb_irq_vmu: $(SRCS) vlog.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_irq_vmu -f vlog.f

clean:
	rm -rf obj_dir
